/* floo_axi_lite_pkg.sv */
package floo_axi_lite_pkg;

  ////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////

  localparam int unsigned AxiAddrWidth = 32;
  localparam int unsigned AxiDataWidth = 32;
  localparam int unsigned AxiStrbWidth = AxiDataWidth / 8;

  typedef logic [AxiAddrWidth-1:0] axi_addr_t;
  typedef logic [AxiDataWidth-1:0] axi_data_t;
  typedef logic [AxiStrbWidth-1:0] axi_strb_t;
  typedef logic [2:0]              axi_prot_t;
  typedef logic [1:0]              axi_resp_t;

  ////////////////////////////////////////
  // Response codes
  ////////////////////////////////////////

  localparam axi_resp_t RespOkay   = 2'b00;
  localparam axi_resp_t RespExOkay = 2'b01;
  localparam axi_resp_t RespSlvErr = 2'b10;
  localparam axi_resp_t RespDecErr = 2'b11;

endpackage

/* floo_noc_pkg.sv */
package floo_noc_pkg;

  import floo_axi_lite_pkg::*;

  ////////////////////////////////////////
  // Address map
  ////////////////////////////////////////

  // Node coordinates sit in fixed address bits, XY routing needs no table
  localparam int unsigned XYAddrOffsetX = 16;
  localparam int unsigned XYAddrOffsetY = 18;
  localparam int unsigned CoordWidth    = 2;

  typedef struct packed {
    logic [CoordWidth-1:0] x;
    logic [CoordWidth-1:0] y;
  } id_t;

  typedef enum logic [2:0] {
    ChAw = 3'd0,
    ChW  = 3'd1,
    ChAr = 3'd2,
    ChB  = 3'd3,
    ChR  = 3'd4
  } axi_ch_e;

  ////////////////////////////////////////
  // Flit layout
  ////////////////////////////////////////

  typedef struct packed {
    id_t     dst_id;
    id_t     src_id;
    axi_ch_e axi_ch;
    logic    last;
  } floo_hdr_t;

  // Request payload, read as AW/AR or as W depending on axi_ch
  typedef struct packed {
    axi_addr_t addr;
    axi_prot_t prot;
    logic      pad;
  } floo_ax_beat_t;

  typedef struct packed {
    axi_data_t data;
    axi_strb_t strb;
  } floo_w_beat_t;

  typedef union packed {
    floo_ax_beat_t ax;
    floo_w_beat_t  w;
  } floo_req_payload_u;

  // Response payload, read as R or as B
  typedef struct packed {
    axi_data_t data;
    axi_resp_t resp;
  } floo_r_beat_t;

  typedef struct packed {
    axi_resp_t resp;
    axi_data_t pad;
  } floo_b_beat_t;

  typedef union packed {
    floo_r_beat_t r;
    floo_b_beat_t b;
  } floo_rsp_payload_u;

  typedef struct packed {
    floo_hdr_t         hdr;
    floo_req_payload_u payload;
  } floo_req_flit_t;

  typedef struct packed {
    floo_hdr_t         hdr;
    floo_rsp_payload_u payload;
  } floo_rsp_flit_t;

endpackage

/* floo_chan_if.sv */
// Request flit channel between ingress and arbiter
interface floo_chan_if import floo_noc_pkg::*; ();

  logic              valid;
  logic              ready;
  floo_hdr_t         hdr;
  floo_req_payload_u payload;

  modport sender (
    output valid,
    output hdr,
    output payload,
    input  ready
  );

  modport receiver (
    input  valid,
    input  hdr,
    input  payload,
    output ready
  );

endinterface

/* floo_lite_ingress.sv */
module floo_lite_ingress import floo_noc_pkg::*, floo_axi_lite_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  input  id_t       id_i,
  input  axi_addr_t awaddr_i,
  input  axi_prot_t awprot_i,
  input  logic      awvalid_i,
  input  axi_data_t wdata_i,
  input  axi_strb_t wstrb_i,
  input  logic      wvalid_i,
  input  axi_addr_t araddr_i,
  input  axi_prot_t arprot_i,
  input  logic      arvalid_i,
  output logic      awready_o,
  output logic      wready_o,
  output logic      arready_o,
  floo_chan_if.sender wr_chan,
  floo_chan_if.sender rd_chan
);

  function automatic id_t addr_to_id(axi_addr_t addr);
    id_t id;
    id.x = addr[XYAddrOffsetX +: CoordWidth];
    id.y = addr[XYAddrOffsetY +: CoordWidth];
    return id;
  endfunction

  logic      aw_valid_q, ar_valid_q;
  axi_addr_t aw_addr_q, ar_addr_q;
  axi_prot_t aw_prot_q, ar_prot_q;
  id_t       aw_dst_q;
  // Low while the write path waits for AW, high while it waits for W
  logic      sel_w_q;

  logic wr_hs, aw_drain, w_hs, ar_drain;
  logic aw_hs, ar_hs;

  assign wr_hs    = wr_chan.valid && wr_chan.ready;
  assign aw_drain = wr_hs && !sel_w_q;
  assign w_hs     = wr_hs && sel_w_q;
  assign ar_drain = rd_chan.valid && rd_chan.ready;

  assign awready_o = awvalid_i && (!aw_valid_q || aw_drain);
  assign arready_o = arvalid_i && (!ar_valid_q || ar_drain);
  assign wready_o  = sel_w_q && wr_chan.ready;
  assign aw_hs     = awvalid_i && awready_o;
  assign ar_hs     = arvalid_i && arready_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      aw_valid_q <= 1'b0;
      ar_valid_q <= 1'b0;
      sel_w_q    <= 1'b0;
    end else begin
      if (aw_hs) aw_valid_q <= 1'b1;
      else if (aw_drain) aw_valid_q <= 1'b0;
      if (ar_hs) ar_valid_q <= 1'b1;
      else if (ar_drain) ar_valid_q <= 1'b0;
      if (aw_drain) sel_w_q <= 1'b1;
      else if (w_hs) sel_w_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      aw_addr_q <= awaddr_i;
      aw_prot_q <= awprot_i;
    end
    if (ar_hs) begin
      ar_addr_q <= araddr_i;
      ar_prot_q <= arprot_i;
    end
    // W follows its AW to the same node
    if (aw_drain) aw_dst_q <= addr_to_id(aw_addr_q);
  end

  ////////////////////////////////////////
  // Flit headers and payloads
  ////////////////////////////////////////

  always_comb begin
    wr_chan.payload    = '0;
    wr_chan.hdr.src_id = id_i;
    if (sel_w_q) begin
      wr_chan.valid          = wvalid_i;
      wr_chan.hdr.dst_id     = aw_dst_q;
      wr_chan.hdr.axi_ch     = ChW;
      wr_chan.hdr.last       = 1'b1;
      wr_chan.payload.w.data = wdata_i;
      wr_chan.payload.w.strb = wstrb_i;
    end else begin
      wr_chan.valid           = aw_valid_q;
      wr_chan.hdr.dst_id      = addr_to_id(aw_addr_q);
      wr_chan.hdr.axi_ch      = ChAw;
      wr_chan.hdr.last        = 1'b0;
      wr_chan.payload.ax.addr = aw_addr_q;
      wr_chan.payload.ax.prot = aw_prot_q;
    end
  end

  always_comb begin
    rd_chan.valid           = ar_valid_q;
    rd_chan.hdr.dst_id      = addr_to_id(ar_addr_q);
    rd_chan.hdr.src_id      = id_i;
    rd_chan.hdr.axi_ch      = ChAr;
    rd_chan.hdr.last        = 1'b1;
    rd_chan.payload         = '0;
    rd_chan.payload.ax.addr = ar_addr_q;
    rd_chan.payload.ax.prot = ar_prot_q;
  end

  // A stalled write flit must not change
  wr_flit_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    wr_chan.valid && !wr_chan.ready |=>
      wr_chan.valid && $stable(wr_chan.hdr) && $stable(wr_chan.payload));

  // After an AW transfer the channel turns to W for the same node
  w_after_aw: assert property (@(posedge clk_i) disable iff (rst_i)
    wr_chan.valid && wr_chan.ready && (wr_chan.hdr.axi_ch == ChAw) |=>
      (wr_chan.hdr.axi_ch == ChW) && (wr_chan.hdr.dst_id == $past(wr_chan.hdr.dst_id)));

endmodule

/* floo_req_arbiter.sv */
module floo_req_arbiter import floo_noc_pkg::*, floo_axi_lite_pkg::*; (
  input  logic           clk_i,
  input  logic           rst_i,
  input  logic           req_ready_i,
  floo_chan_if.receiver  wr_chan,
  floo_chan_if.receiver  rd_chan,
  output floo_req_flit_t req_flit_o,
  output logic           req_valid_o
);

  logic           out_valid_q;
  floo_req_flit_t out_flit_q;
  // Set between an AW flit and the W flit that closes the pair
  logic           wr_lock_q;
  // Round-robin pointer, high when the read side goes first
  logic           rd_prio_q;
  logic           last_aw_q;

  logic out_free, gnt_wr, gnt_rd;
  logic wr_load, rd_load;

  assign out_free = !out_valid_q || req_ready_i;

  ////////////////////////////////////////
  // Grant
  ////////////////////////////////////////

  assign gnt_wr = wr_chan.valid && (wr_lock_q || !rd_chan.valid || !rd_prio_q);
  assign gnt_rd = rd_chan.valid && !wr_lock_q && !gnt_wr;

  assign wr_chan.ready = out_free && gnt_wr;
  assign rd_chan.ready = out_free && gnt_rd;
  assign wr_load       = wr_chan.valid && wr_chan.ready;
  assign rd_load       = rd_chan.valid && rd_chan.ready;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_valid_q <= 1'b0;
      wr_lock_q   <= 1'b0;
      rd_prio_q   <= 1'b0;
    end else begin
      if (wr_load || rd_load) out_valid_q <= 1'b1;
      else if (req_ready_i) out_valid_q <= 1'b0;
      if (wr_load && (wr_chan.hdr.axi_ch == ChAw)) begin
        wr_lock_q <= 1'b1;
      end else if (wr_load && wr_chan.hdr.last) begin
        wr_lock_q <= 1'b0;
        rd_prio_q <= 1'b1;
      end
      if (rd_load) rd_prio_q <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // Output register
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (wr_load) begin
      out_flit_q <= '{hdr: wr_chan.hdr, payload: wr_chan.payload};
    end else if (rd_load) begin
      out_flit_q <= '{hdr: rd_chan.hdr, payload: rd_chan.payload};
    end
  end

  assign req_flit_o  = out_flit_q;
  assign req_valid_o = out_valid_q;

  // Channel of the previous flit that left on the link
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      last_aw_q <= 1'b0;
    end else if (req_valid_o && req_ready_i) begin
      last_aw_q <= (req_flit_o.hdr.axi_ch == ChAw);
    end
  end

  w_follows_aw: assert property (@(posedge clk_i) disable iff (rst_i)
    req_valid_o && (req_flit_o.hdr.axi_ch == ChW) |-> last_aw_q);

endmodule

/* floo_rsp_unpacker.sv */
module floo_rsp_unpacker import floo_noc_pkg::*, floo_axi_lite_pkg::*; (
  input  logic           clk_i,
  input  logic           rst_i,
  input  floo_rsp_flit_t rsp_flit_i,
  input  logic           rsp_valid_i,
  output logic           rsp_ready_o,
  output axi_resp_t      bresp_o,
  output logic           bvalid_o,
  input  logic           bready_i,
  output axi_data_t      rdata_o,
  output axi_resp_t      rresp_o,
  output logic           rvalid_o,
  input  logic           rready_i
);

  logic      b_valid_q, r_valid_q;
  axi_resp_t b_resp_q, r_resp_q;
  axi_data_t r_data_q;

  logic is_b, is_r;
  logic b_accept, r_accept;

  assign is_b = (rsp_flit_i.hdr.axi_ch == ChB);
  assign is_r = (rsp_flit_i.hdr.axi_ch == ChR);

  // Each channel only waits on its own slot
  assign rsp_ready_o = (is_b && !b_valid_q) || (is_r && !r_valid_q);
  assign b_accept    = rsp_valid_i && is_b && !b_valid_q;
  assign r_accept    = rsp_valid_i && is_r && !r_valid_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      if (b_accept) b_valid_q <= 1'b1;
      else if (bready_i) b_valid_q <= 1'b0;
      if (r_accept) r_valid_q <= 1'b1;
      else if (rready_i) r_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (b_accept) b_resp_q <= rsp_flit_i.payload.b.resp;
    if (r_accept) begin
      r_data_q <= rsp_flit_i.payload.r.data;
      r_resp_q <= rsp_flit_i.payload.r.resp;
    end
  end

  assign bresp_o  = b_resp_q;
  assign bvalid_o = b_valid_q;
  assign rdata_o  = r_data_q;
  assign rresp_o  = r_resp_q;
  assign rvalid_o = r_valid_q;

  // The network must only deliver responses here, anything else would block the link
  rsp_channel_valid: assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_valid_i |-> (rsp_flit_i.hdr.axi_ch inside {ChB, ChR}));

endmodule

/* floo_lite_chimney.sv */
module floo_lite_chimney import floo_noc_pkg::*, floo_axi_lite_pkg::*; (
  input  logic           clk_i,
  input  logic           rst_i,
  input  id_t            id_i,
  input  axi_addr_t      s_awaddr_i,
  input  axi_prot_t      s_awprot_i,
  input  logic           s_awvalid_i,
  output logic           s_awready_o,
  input  axi_data_t      s_wdata_i,
  input  axi_strb_t      s_wstrb_i,
  input  logic           s_wvalid_i,
  output logic           s_wready_o,
  output axi_resp_t      s_bresp_o,
  output logic           s_bvalid_o,
  input  logic           s_bready_i,
  input  axi_addr_t      s_araddr_i,
  input  axi_prot_t      s_arprot_i,
  input  logic           s_arvalid_i,
  output logic           s_arready_o,
  output axi_data_t      s_rdata_o,
  output axi_resp_t      s_rresp_o,
  output logic           s_rvalid_o,
  input  logic           s_rready_i,
  output floo_req_flit_t req_flit_o,
  output logic           req_valid_o,
  input  logic           req_ready_i,
  input  floo_rsp_flit_t rsp_flit_i,
  input  logic           rsp_valid_i,
  output logic           rsp_ready_o
);

  // AW and W share one channel, AR has its own
  floo_chan_if wr_chan ();
  floo_chan_if rd_chan ();

  floo_lite_ingress i_ingress (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .id_i      (id_i),
    .awaddr_i  (s_awaddr_i),
    .awprot_i  (s_awprot_i),
    .awvalid_i (s_awvalid_i),
    .wdata_i   (s_wdata_i),
    .wstrb_i   (s_wstrb_i),
    .wvalid_i  (s_wvalid_i),
    .araddr_i  (s_araddr_i),
    .arprot_i  (s_arprot_i),
    .arvalid_i (s_arvalid_i),
    .awready_o (s_awready_o),
    .wready_o  (s_wready_o),
    .arready_o (s_arready_o),
    .wr_chan   (wr_chan.sender),
    .rd_chan   (rd_chan.sender)
  );

  floo_req_arbiter i_req_arbiter (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_ready_i (req_ready_i),
    .wr_chan     (wr_chan.receiver),
    .rd_chan     (rd_chan.receiver),
    .req_flit_o  (req_flit_o),
    .req_valid_o (req_valid_o)
  );

  floo_rsp_unpacker i_rsp_unpacker (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .rsp_flit_i  (rsp_flit_i),
    .rsp_valid_i (rsp_valid_i),
    .rsp_ready_o (rsp_ready_o),
    .bresp_o     (s_bresp_o),
    .bvalid_o    (s_bvalid_o),
    .bready_i    (s_bready_i),
    .rdata_o     (s_rdata_o),
    .rresp_o     (s_rresp_o),
    .rvalid_o    (s_rvalid_o),
    .rready_i    (s_rready_i)
  );

endmodule

/* tb_floo_lite_chimney.sv */
module tb_floo_lite_chimney import floo_noc_pkg::*, floo_axi_lite_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned ClkPeriod     = 40;
  localparam int unsigned DriveDelay    = 2;
  localparam int unsigned TimeoutCycles = 500;
  localparam int unsigned RandomTxns    = 40;

  logic           clk_i, rst_i;
  id_t            id_i;
  axi_addr_t      s_awaddr_i, s_araddr_i;
  axi_prot_t      s_awprot_i, s_arprot_i;
  axi_data_t      s_wdata_i, s_rdata_o;
  axi_strb_t      s_wstrb_i;
  axi_resp_t      s_bresp_o, s_rresp_o;
  logic           s_awvalid_i, s_wvalid_i, s_arvalid_i, s_bready_i, s_rready_i;
  logic           s_awready_o, s_wready_o, s_arready_o, s_bvalid_o, s_rvalid_o;
  floo_req_flit_t req_flit_o;
  logic           req_valid_o, req_ready_i;
  floo_rsp_flit_t rsp_flit_i;
  logic           rsp_valid_i, rsp_ready_o;

  integer         seed;
  int unsigned    errors;
  logic           toggle_en;
  // Last flit on the request link was an AW
  logic           prev_aw;
  floo_req_flit_t wr_exp_q[$];
  floo_req_flit_t rd_exp_q[$];
  axi_resp_t      b_exp_q[$];
  floo_r_beat_t   r_exp_q[$];

  floo_lite_chimney DUT (.*);

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  ////////////////////////////////////////
  // Reference model and checks
  ////////////////////////////////////////

  function automatic floo_req_flit_t expected_req_flit(input axi_ch_e ch, input axi_addr_t addr,
      input axi_prot_t prot, input axi_data_t data, input axi_strb_t strb);
    floo_req_flit_t flit;
    flit = '0;
    // Destination node sits in the address, W reuses its AW address
    flit.hdr.dst_id.x = addr[XYAddrOffsetX +: CoordWidth];
    flit.hdr.dst_id.y = addr[XYAddrOffsetY +: CoordWidth];
    flit.hdr.src_id   = id_i;
    flit.hdr.axi_ch   = ch;
    flit.hdr.last     = (ch != ChAw);
    if (ch == ChW) begin
      flit.payload.w.data = data;
      flit.payload.w.strb = strb;
    end else begin
      flit.payload.ax.addr = addr;
      flit.payload.ax.prot = prot;
    end
    return flit;
  endfunction

  task automatic stop_on_error();
    errors++;
    $display("Done: errors found");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic report_failure(input string what);
    $display("t=%0d ns: %s", $time, what);
    stop_on_error();
  endtask

  task automatic check_low(input string name, input logic act);
    if (act !== 1'b0) begin
      $display("[ERROR] t=%0d ns %s expected 0 got %b", $time, name, act);
      stop_on_error();
    end
  endtask

  task automatic check_req_flit(input floo_req_flit_t exp, input floo_req_flit_t act);
    if (act !== exp) begin
      $display("[ERROR] t=%0d ns req_flit_o expected %h got %h", $time, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_bresp(input axi_resp_t exp, input axi_resp_t act);
    if (act !== exp) begin
      $display("[ERROR] t=%0d ns s_bresp_o expected %h got %h", $time, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_rdata(input axi_data_t exp_data, input axi_resp_t exp_resp,
                             input axi_data_t act_data, input axi_resp_t act_resp);
    if (act_data !== exp_data || act_resp !== exp_resp) begin
      $display("[ERROR] t=%0d ns s_rdata_o/s_rresp_o expected %h/%h got %h/%h",
               $time, exp_data, exp_resp, act_data, act_resp);
      stop_on_error();
    end
  endtask

  task automatic take_req_flit(input floo_req_flit_t act);
    if (prev_aw && act.hdr.axi_ch != ChW) begin
      report_failure("AW flit not followed directly by its W flit");
    end else if (!prev_aw && act.hdr.axi_ch == ChW) begin
      report_failure("W flit on the link without an AW flit before it");
    end
    prev_aw = (act.hdr.axi_ch == ChAw);
    case (act.hdr.axi_ch)
      ChAw, ChW: begin
        if (wr_exp_q.size() == 0) report_failure("Write flit on the link with no write issued");
        else check_req_flit(wr_exp_q.pop_front(), act);
      end
      ChAr: begin
        if (rd_exp_q.size() == 0) report_failure("AR flit on the link with no read issued");
        else check_req_flit(rd_exp_q.pop_front(), act);
      end
      default: report_failure("Request link carries a flit with a response channel code");
    endcase
  endtask

  task automatic take_b_beat();
    if (b_exp_q.size() == 0) report_failure("B beat on the AXI port with no B flit sent");
    else check_bresp(b_exp_q.pop_front(), s_bresp_o);
  endtask

  task automatic take_r_beat();
    floo_r_beat_t exp;
    if (r_exp_q.size() == 0) begin
      report_failure("R beat on the AXI port with no R flit sent");
    end else begin
      exp = r_exp_q.pop_front();
      check_rdata(exp.data, exp.resp, s_rdata_o, s_rresp_o);
    end
  endtask

  // Outputs are sampled mid-cycle, a transfer then happens on the next rising edge
  always @(negedge clk_i) begin
    if (!rst_i && req_valid_o && req_ready_i) take_req_flit(req_flit_o);
    if (!rst_i && s_bvalid_o && s_bready_i) take_b_beat();
    if (!rst_i && s_rvalid_o && s_rready_i) take_r_beat();
  end

  ////////////////////////////////////////
  // Manager and network drivers
  ////////////////////////////////////////

  function automatic axi_data_t rand_word();
    return $random(seed);
  endfunction

  function automatic logic accept_seen(input axi_ch_e ch);
    case (ch)
      ChAw:    return s_awready_o;
      ChW:     return s_wready_o;
      ChAr:    return s_arready_o;
      default: return rsp_ready_o && rsp_valid_i;
    endcase
  endfunction

  task automatic next_drive_slot();
    @(posedge clk_i);
    #DriveDelay;
  endtask

  task automatic await_accept(input axi_ch_e ch, input string what);
    int unsigned cycles;
    cycles = 0;
    @(negedge clk_i);
    while (!accept_seen(ch)) begin
      cycles++;
      if (cycles > TimeoutCycles) report_failure({"Timeout waiting for ", what});
      @(negedge clk_i);
    end
  endtask

  task automatic wait_drained();
    int unsigned cycles;
    cycles = 0;
    while (wr_exp_q.size() + rd_exp_q.size() + b_exp_q.size() + r_exp_q.size() != 0) begin
      cycles++;
      if (cycles > TimeoutCycles) report_failure("Timeout waiting for outstanding beats");
      @(negedge clk_i);
    end
    next_drive_slot();
  endtask

  task automatic do_write(input axi_addr_t addr, input axi_prot_t prot,
                          input axi_data_t data, input axi_strb_t strb);
    s_awaddr_i  = addr;
    s_awprot_i  = prot;
    s_awvalid_i = 1'b1;
    await_accept(ChAw, "AW handshake");
    wr_exp_q.push_back(expected_req_flit(ChAw, addr, prot, '0, '0));
    next_drive_slot();
    s_awvalid_i = 1'b0;
    s_wdata_i   = data;
    s_wstrb_i   = strb;
    s_wvalid_i  = 1'b1;
    await_accept(ChW, "W handshake");
    wr_exp_q.push_back(expected_req_flit(ChW, addr, '0, data, strb));
    next_drive_slot();
    s_wvalid_i = 1'b0;
  endtask

  task automatic do_read(input axi_addr_t addr, input axi_prot_t prot);
    s_araddr_i  = addr;
    s_arprot_i  = prot;
    s_arvalid_i = 1'b1;
    await_accept(ChAr, "AR handshake");
    rd_exp_q.push_back(expected_req_flit(ChAr, addr, prot, '0, '0));
    next_drive_slot();
    s_arvalid_i = 1'b0;
  endtask

  task automatic send_rsp(input axi_ch_e ch, input axi_data_t data, input axi_resp_t resp);
    floo_rsp_flit_t flit;
    floo_r_beat_t   beat;
    flit            = '0;
    flit.hdr.dst_id = id_i;
    flit.hdr.axi_ch = ch;
    flit.hdr.last   = 1'b1;
    if (ch == ChB) begin
      flit.payload.b.resp = resp;
    end else begin
      flit.payload.r.data = data;
      flit.payload.r.resp = resp;
    end
    rsp_flit_i  = flit;
    rsp_valid_i = 1'b1;
    await_accept(ch, "response link ready");
    beat.data = data;
    beat.resp = resp;
    if (ch == ChB) b_exp_q.push_back(resp);
    else r_exp_q.push_back(beat);
    next_drive_slot();
    rsp_valid_i = 1'b0;
  endtask

  task automatic random_writes(input int unsigned count);
    axi_data_t word;
    repeat (count) begin
      word = rand_word();
      do_write(rand_word(), word[2:0], rand_word(), word[7:4]);
      repeat (word[9:8]) next_drive_slot();
    end
  endtask

  task automatic random_reads(input int unsigned count);
    axi_data_t word;
    repeat (count) begin
      word = rand_word();
      do_read(rand_word(), word[2:0]);
      repeat (word[5:4]) next_drive_slot();
    end
  endtask

  task automatic random_rsps(input int unsigned count);
    axi_data_t word;
    repeat (count) begin
      word = rand_word();
      send_rsp(word[0] ? ChB : ChR, rand_word(), word[2:1]);
      repeat (word[5:4]) next_drive_slot();
    end
  endtask

  // Ready about three cycles in four while enabled
  task automatic toggle_readies();
    axi_data_t rnd;
    rnd         = rand_word();
    req_ready_i = rnd[0] | rnd[1];
    s_bready_i  = rnd[2] | rnd[3];
    s_rready_i  = rnd[4] | rnd[5];
  endtask

  always @(posedge clk_i) begin
    if (toggle_en) begin
      #DriveDelay;
      toggle_readies();
    end
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    seed        = 32'h5c51a5a4;
    errors      = 0;
    toggle_en   = 1'b0;
    prev_aw     = 1'b0;
    clk_i       = 1'b0;
    rst_i       = 1'b1;
    id_i        = '{x: 2'd1, y: 2'd2};
    s_awaddr_i  = '0;
    s_awprot_i  = '0;
    s_awvalid_i = 1'b0;
    s_wdata_i   = '0;
    s_wstrb_i   = '0;
    s_wvalid_i  = 1'b0;
    s_araddr_i  = '0;
    s_arprot_i  = '0;
    s_arvalid_i = 1'b0;
    s_bready_i  = 1'b1;
    s_rready_i  = 1'b1;
    req_ready_i = 1'b1;
    rsp_flit_i  = '0;
    rsp_valid_i = 1'b0;
    repeat (10) @(posedge clk_i);
    #DriveDelay;
    rst_i = 1'b0;

    // Quiet outputs while the manager is idle
    repeat (3) begin
      @(negedge clk_i);
      check_low("s_awready_o", s_awready_o);
      check_low("s_wready_o", s_wready_o);
      check_low("s_arready_o", s_arready_o);
      check_low("s_bvalid_o", s_bvalid_o);
      check_low("s_rvalid_o", s_rvalid_o);
      check_low("req_valid_o", req_valid_o);
    end
    next_drive_slot();

    do_write(32'h000b_1230, 3'b010, 32'hcafe_f00d, 4'b1011);
    wait_drained();
    do_read(32'h0006_4444, 3'b001);
    wait_drained();
    send_rsp(ChB, '0, RespSlvErr);
    send_rsp(ChR, 32'h1234_5678, RespExOkay);
    wait_drained();

    // Mixed traffic under random back-pressure
    toggle_en = 1'b1;
    fork
      random_writes(RandomTxns);
      random_reads(RandomTxns);
      random_rsps(RandomTxns);
    join
    toggle_en = 1'b0;
    next_drive_slot();
    req_ready_i = 1'b1;
    s_bready_i  = 1'b1;
    s_rready_i  = 1'b1;
    wait_drained();

    if (errors != 0) begin
      stop_on_error();
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

/* tb.f */
floo_axi_lite_pkg.sv
floo_noc_pkg.sv
floo_chan_if.sv
floo_lite_ingress.sv
floo_req_arbiter.sv
floo_rsp_unpacker.sv
floo_lite_chimney.sv
tb_floo_lite_chimney.sv

/* Makefile */
# Verilator flow for the AXI4-Lite chimney testbench

VERILATOR ?= verilator
FILELIST  ?= tb.f
TOP       ?= tb_floo_lite_chimney
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Done: no errors
VFLAGS    ?= --timing --assert --timescale 1ns/100ps

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# The log decides pass or fail, the pipe hides the simulator status
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
